//--- source/layer_norm_pkg.sv
`default_nettype none

package layer_norm_pkg;

    // Vector geometry, depth must stay a power of two
    localparam int DEPTH      = 8;
    localparam int DEPTH_LOG2 = $clog2(DEPTH);
    localparam int IDX_W      = DEPTH_LOG2;

    // Q4.4 samples, gamma and beta
    localparam int ELEM_W = 8;
    localparam int FRAC_W = 4;

    // Derived datapath widths
    localparam int DIFF_W     = ELEM_W + 1;
    localparam int SUM_W      = ELEM_W + DEPTH_LOG2;
    localparam int VAR_W      = 20;
    localparam int STD_W      = VAR_W / 2;
    localparam int REM_W      = STD_W + 2;
    localparam int STEP_CNT_W = $clog2(STD_W);
    localparam int PROD_W     = DIFF_W + ELEM_W;
    localparam int CFG_ADDR_W = 5;

    typedef logic signed [ELEM_W-1:0]       elem_t;
    typedef logic [DEPTH*ELEM_W-1:0]        vec_t;
    typedef logic signed [DIFF_W-1:0]       diff_t;
    typedef logic [DEPTH*DIFF_W-1:0]        diff_vec_t;
    typedef logic [VAR_W-1:0]               var_t;
    typedef logic [STD_W-1:0]               std_t;
    typedef logic [CFG_ADDR_W-1:0]          cfg_addr_t;

    // One LSB of the standard deviation, keeps the divisor nonzero
    localparam std_t EPSILON = 10'd1;

    // Saturation limits of the output
    localparam elem_t ELEM_MAX = 8'h7f;
    localparam elem_t ELEM_MIN = 8'h80;

    // Configuration address map
    localparam cfg_addr_t CFG_GAMMA_BASE = 5'd0;
    localparam cfg_addr_t CFG_BETA_BASE  = 5'd8;
    localparam elem_t     GAMMA_RESET    = 8'sd16;

    typedef enum logic [1:0] {IDLE, RUN, HOLD} scale_state_t;

endpackage

`default_nettype wire

//--- source/norm_stats.sv
`timescale 1ns/10ps
`default_nettype none

module norm_stats
    import layer_norm_pkg::*;
(
    input  wire             clk,
    input  wire             rst_n,
    input  wire vec_t       in_data,
    input  wire             in_valid,
    output logic            in_ready,
    output logic            st_valid,
    input  wire             st_ready,
    output var_t            st_var,
    output diff_vec_t       st_diff
);

    elem_t                   sample [DEPTH];
    diff_t                   diff   [DEPTH];
    logic [2*DIFF_W-1:0]     square [DEPTH];
    logic signed [SUM_W-1:0] sum;
    logic signed [SUM_W-1:0] mean_wide;
    elem_t                   mean;
    logic [VAR_W-1:0]        sum_sq;
    var_t                    variance;
    diff_vec_t               diff_vec;
    logic                    take;

    // Whole statistics pass is combinational on the input vector
    always_comb
    begin
        sum = '0;
        for (int i = 0; i < DEPTH; i++)
        begin
            sample[i] = in_data[i*ELEM_W +: ELEM_W];
            sum       = sum + sample[i];
        end

        // Arithmetic shift gives the floor of the mean
        mean_wide = sum >>> DEPTH_LOG2;
        mean      = mean_wide[ELEM_W-1:0];

        sum_sq = '0;
        for (int i = 0; i < DEPTH; i++)
        begin
            diff[i]   = sample[i] - mean;
            square[i] = diff[i] * diff[i];
            sum_sq    = sum_sq + square[i];
            diff_vec[i*DIFF_W +: DIFF_W] = diff[i];
        end

        // Variance keeps 8 fractional bits from the squared Q5.4 terms
        variance = sum_sq >> DEPTH_LOG2;
    end

    // One-entry output slot, refilled in the cycle it drains
    assign in_ready = !st_valid || st_ready;
    assign take     = in_valid && in_ready;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            st_valid <= 1'b0;
        else if (take)
            st_valid <= 1'b1;
        else if (st_ready)
            st_valid <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (take)
        begin
            st_var  <= variance;
            st_diff <= diff_vec;
        end
    end

endmodule

`default_nettype wire

//--- source/isqrt_unit.sv
`timescale 1ns/10ps
`default_nettype none

module isqrt_unit
    import layer_norm_pkg::*;
(
    input  wire             clk,
    input  wire             rst_n,
    input  wire             st_valid,
    output logic            st_ready,
    input  wire var_t       st_var,
    input  wire diff_vec_t  st_diff,
    output logic            sq_valid,
    input  wire             sq_ready,
    output std_t            sq_std,
    output diff_vec_t       sq_diff
);

    logic                  busy;
    logic [STEP_CNT_W-1:0] step;
    var_t                  radicand;
    logic [REM_W-1:0]      rem;
    std_t                  root;
    logic [REM_W+1:0]      rem_shift;
    logic [REM_W+2:0]      rem_trial;
    logic                  take;

    // Only accepts when both the iteration and the result slot are free
    assign st_ready = !busy && !sq_valid;
    assign take     = st_valid && st_ready;
    assign sq_std   = root;

    // Bring down the next bit pair and try subtracting 4*root + 1
    always_comb
    begin
        rem_shift = {rem, radicand[VAR_W-1 -: 2]};
        rem_trial = {1'b0, rem_shift} - {root, 2'b01};
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            busy     <= 1'b0;
            sq_valid <= 1'b0;
            step     <= '0;
        end
        else
        begin
            if (take)
            begin
                busy <= 1'b1;
                step <= '0;
            end
            else if (busy)
            begin
                step <= step + 1'b1;
                // Last root bit settles on this edge
                if (step == STD_W - 1)
                begin
                    busy     <= 1'b0;
                    sq_valid <= 1'b1;
                end
            end
            if (sq_valid && sq_ready)
                sq_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (take)
        begin
            radicand <= st_var;
            rem      <= '0;
            root     <= '0;
            sq_diff  <= st_diff;
        end
        else if (busy)
        begin
            radicand <= radicand << 2;
            if (rem_trial[REM_W+2])
            begin
                // Borrow, restore the remainder and append a zero bit
                rem  <= rem_shift[REM_W-1:0];
                root <= {root[STD_W-2:0], 1'b0};
            end
            else
            begin
                rem  <= rem_trial[REM_W-1:0];
                root <= {root[STD_W-2:0], 1'b1};
            end
        end
    end

endmodule

`default_nettype wire

//--- source/affine_params.sv
`timescale 1ns/10ps
`default_nettype none

module affine_params
    import layer_norm_pkg::*;
(
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  cfg_wr_en,
    input  wire cfg_addr_t       cfg_addr,
    input  wire elem_t           cfg_wdata,
    output elem_t                cfg_rdata,
    input  wire [IDX_W-1:0]      elem_idx,
    output elem_t                gamma_sel,
    output elem_t                beta_sel
);

    elem_t            gamma_q [DEPTH];
    elem_t            beta_q  [DEPTH];
    logic             gamma_hit;
    logic             beta_hit;
    logic [IDX_W-1:0] slot;

    // Bases are aligned to DEPTH, so the upper address bits select the bank
    assign slot      = cfg_addr[IDX_W-1:0];
    assign gamma_hit = cfg_addr[CFG_ADDR_W-1:IDX_W] == CFG_GAMMA_BASE[CFG_ADDR_W-1:IDX_W];
    assign beta_hit  = cfg_addr[CFG_ADDR_W-1:IDX_W] == CFG_BETA_BASE[CFG_ADDR_W-1:IDX_W];

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < DEPTH; i++)
            begin
                gamma_q[i] <= GAMMA_RESET;
                beta_q[i]  <= '0;
            end
        end
        else if (cfg_wr_en)
        begin
            if (gamma_hit)
                gamma_q[slot] <= cfg_wdata;
            else if (beta_hit)
                beta_q[slot] <= cfg_wdata;
        end
    end

    // Unmapped addresses read as zero
    always_comb
    begin
        if (gamma_hit)
            cfg_rdata = gamma_q[slot];
        else if (beta_hit)
            cfg_rdata = beta_q[slot];
        else
            cfg_rdata = '0;
    end

    assign gamma_sel = gamma_q[elem_idx];
    assign beta_sel  = beta_q[elem_idx];

endmodule

`default_nettype wire

//--- source/norm_scale.sv
`timescale 1ns/10ps
`default_nettype none

module norm_scale
    import layer_norm_pkg::*;
(
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  sq_valid,
    output logic                 sq_ready,
    input  wire std_t            sq_std,
    input  wire diff_vec_t       sq_diff,
    output logic [IDX_W-1:0]     elem_idx,
    input  wire elem_t           gamma_sel,
    input  wire elem_t           beta_sel,
    output vec_t                 out_data,
    output logic                 out_valid,
    input  wire                  out_ready
);

    scale_state_t             state;
    logic [IDX_W-1:0]         idx;
    diff_vec_t                diff_q;
    logic [STD_W:0]           divisor_q;
    vec_t                     out_q;
    diff_t                    diff_cur;
    logic signed [PROD_W-1:0] prod;
    logic signed [PROD_W-1:0] quot;
    logic signed [PROD_W:0]   shifted;
    elem_t                    sat;
    logic                     take;

    assign sq_ready  = state == IDLE;
    assign out_valid = state == HOLD;
    assign out_data  = out_q;
    assign elem_idx  = idx;
    assign take      = sq_valid && sq_ready;

    // Per-element datapath for the element under idx
    always_comb
    begin
        diff_cur = diff_q[idx*DIFF_W +: DIFF_W];
        // Q5.4 times Q4.4 leaves 8 fractional bits
        prod     = diff_cur * gamma_sel;
        // Signed divide truncates toward zero, result back to 4 fractional bits
        quot     = prod / $signed({1'b0, divisor_q});
        shifted  = quot + beta_sel;

        if (shifted > ELEM_MAX)
            sat = ELEM_MAX;
        else if (shifted < ELEM_MIN)
            sat = ELEM_MIN;
        else
            sat = shifted[ELEM_W-1:0];
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state <= IDLE;
            idx   <= '0;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (take)
                    begin
                        state <= RUN;
                        idx   <= '0;
                    end
                end
                RUN:
                begin
                    idx <= idx + 1'b1;
                    if (idx == DEPTH - 1)
                        state <= HOLD;
                end
                HOLD:
                begin
                    // Output vector stays put until the sink takes it
                    if (out_ready)
                        state <= IDLE;
                end
                default:
                    state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (take)
        begin
            diff_q    <= sq_diff;
            divisor_q <= sq_std + EPSILON;
        end
        if (state == RUN)
            out_q[idx*ELEM_W +: ELEM_W] <= sat;
    end

endmodule

`default_nettype wire

//--- source/layer_norm_top.sv
`timescale 1ns/10ps
`default_nettype none

module layer_norm_top
    import layer_norm_pkg::*;
(
    input  wire              clk,
    input  wire              rst_n,

    // Input vector stream
    input  wire vec_t        in_data,
    input  wire              in_valid,
    output logic             in_ready,

    // Output vector stream
    output vec_t             out_data,
    output logic             out_valid,
    input  wire              out_ready,

    // Configuration port for gamma and beta
    input  wire              cfg_wr_en,
    input  wire cfg_addr_t   cfg_addr,
    input  wire elem_t       cfg_wdata,
    output elem_t            cfg_rdata
);

    // Stats to root
    logic             st_valid;
    logic             st_ready;
    var_t             st_var;
    diff_vec_t        st_diff;

    // Root to scale
    logic             sq_valid;
    logic             sq_ready;
    std_t             sq_std;
    diff_vec_t        sq_diff;

    // Scale to parameter block
    logic [IDX_W-1:0] elem_idx;
    elem_t            gamma_sel;
    elem_t            beta_sel;

    norm_stats u_norm_stats (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_data  (in_data),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .st_valid (st_valid),
        .st_ready (st_ready),
        .st_var   (st_var),
        .st_diff  (st_diff)
    );

    isqrt_unit u_isqrt_unit (
        .clk      (clk),
        .rst_n    (rst_n),
        .st_valid (st_valid),
        .st_ready (st_ready),
        .st_var   (st_var),
        .st_diff  (st_diff),
        .sq_valid (sq_valid),
        .sq_ready (sq_ready),
        .sq_std   (sq_std),
        .sq_diff  (sq_diff)
    );

    norm_scale u_norm_scale (
        .clk       (clk),
        .rst_n     (rst_n),
        .sq_valid  (sq_valid),
        .sq_ready  (sq_ready),
        .sq_std    (sq_std),
        .sq_diff   (sq_diff),
        .elem_idx  (elem_idx),
        .gamma_sel (gamma_sel),
        .beta_sel  (beta_sel),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    affine_params u_affine_params (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_wr_en (cfg_wr_en),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata),
        .elem_idx  (elem_idx),
        .gamma_sel (gamma_sel),
        .beta_sel  (beta_sel)
    );

endmodule

`default_nettype wire

//--- tests/layer_norm_checker.sv
`timescale 1ns/10ps
`default_nettype none

module layer_norm_checker
    import layer_norm_pkg::*;
(
    input wire       clk,
    input wire       rst_n,
    input wire vec_t in_data,
    input wire       in_valid,
    input wire       in_ready,
    input wire vec_t out_data,
    input wire       out_valid,
    input wire       out_ready
);

    int fail_count = 0;

    // Synchronous reset clears the scale FSM on the edge where it is seen
    property out_idle_after_reset;
        @(posedge clk) !rst_n |=> !out_valid;
    endproperty

    // A stalled output vector must not change or vanish
    property out_held_while_stalled;
        @(posedge clk) disable iff (!rst_n)
            out_valid && !out_ready |=> out_valid && $stable(out_data);
    endproperty

    // The source keeps its offer until the engine takes it
    property in_held_until_ready;
        @(posedge clk) disable iff (!rst_n)
            in_valid && !in_ready |=> in_valid && $stable(in_data);
    endproperty

    assert property (out_idle_after_reset)
    else
    begin
        $error("out_valid is high in the cycle after reset");
        fail_count++;
    end

    assert property (out_held_while_stalled)
    else
    begin
        $error("out_valid or out_data changed while out_ready was low");
        fail_count++;
    end

    assert property (in_held_until_ready)
    else
    begin
        $error("in_valid or in_data changed before in_ready");
        fail_count++;
    end

endmodule

bind layer_norm_top layer_norm_checker u_checker (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_data   (in_data),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_data  (out_data),
    .out_valid (out_valid),
    .out_ready (out_ready)
);

`default_nettype wire

//--- tests/layer_norm_tb.sv
`timescale 1ns/10ps
`default_nettype none

module layer_norm_tb
    import layer_norm_pkg::*;
();

    localparam logic [31:0] SEED = 32'd81897;
    // Vector counts per test set the watchdog budget
    localparam int CONST_VECTORS   = 4;
    localparam int RANDOM_VECTORS  = 40;
    localparam int TOTAL_VECTORS   = 2 * CONST_VECTORS + 3 * RANDOM_VECTORS;
    localparam int WATCHDOG_CYCLES = TOTAL_VECTORS * 30 + 1000;

    logic        clk;
    logic        rst_n;
    vec_t        in_data;
    logic        in_valid;
    logic        in_ready;
    vec_t        out_data;
    logic        out_valid;
    logic        out_ready;
    logic        cfg_wr_en;
    cfg_addr_t   cfg_addr;
    elem_t       cfg_wdata;
    elem_t       cfg_rdata;

    vec_t        exp_q [$];
    int          gamma_model [DEPTH];
    int          beta_model [DEPTH];
    logic [31:0] stim_seed;
    logic [31:0] sink_seed;
    logic        ready_random;
    int          errors;
    int          checker_fails_seen;
    int          tests_run;
    int          tests_failed;
    int          vectors_checked;
    int          sat_hi;
    int          sat_lo;

    layer_norm_top UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_data   (in_data),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .cfg_wr_en (cfg_wr_en),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [7:0] rand_byte();
        stim_seed = lcg_step(stim_seed);
        return stim_seed[23:16];
    endfunction

    function automatic vec_t random_vector();
        vec_t v;
        for (int i = 0; i < DEPTH; i++)
            v[i*ELEM_W +: ELEM_W] = rand_byte();
        return v;
    endfunction

    // Floor square root found bit by bit from the top
    function automatic int int_sqrt(input int v);
        int r;
        r = 0;
        for (int b = 9; b >= 0; b--)
        begin
            if ((r + (1 << b)) * (r + (1 << b)) <= v)
                r = r + (1 << b);
        end
        return r;
    endfunction

    // Reference normalisation with the current gamma and beta model
    function automatic vec_t expected_vector(input vec_t x);
        int   d [DEPTH];
        int   s;
        int   mean;
        int   v;
        int   divisor;
        int   o;
        vec_t y;
        s = 0;
        for (int i = 0; i < DEPTH; i++)
            s = s + $signed(x[i*ELEM_W +: ELEM_W]);
        mean = s >>> DEPTH_LOG2;
        v = 0;
        for (int i = 0; i < DEPTH; i++)
        begin
            d[i] = $signed(x[i*ELEM_W +: ELEM_W]) - mean;
            v    = v + d[i] * d[i];
        end
        v       = v >> DEPTH_LOG2;
        divisor = int_sqrt(v) + int'(EPSILON);
        for (int i = 0; i < DEPTH; i++)
        begin
            // Integer division truncates toward zero
            o = (d[i] * gamma_model[i]) / divisor + beta_model[i];
            if (o > 127)
                o = 127;
            else if (o < -128)
                o = -128;
            y[i*ELEM_W +: ELEM_W] = 8'(o);
        end
        return y;
    endfunction

    task automatic report_mismatch(input string name, input int expected, input int actual);
        $display("[FAIL] t=%0t %s expected %0d actual %0d", $time, name, expected, actual);
        errors++;
    endtask

    task automatic write_param(input cfg_addr_t addr, input elem_t data);
        cfg_wr_en = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        @(negedge clk);
        cfg_wr_en = 1'b0;
        if (addr < DEPTH)
            gamma_model[addr] = data;
        else if (addr < 2 * DEPTH)
            beta_model[addr - DEPTH] = data;
    endtask

    task automatic read_param(input cfg_addr_t addr, output elem_t data);
        cfg_addr = addr;
        @(negedge clk);
        data = cfg_rdata;
    endtask

    // Read back every configuration address against the gamma and beta model
    task automatic check_param_readback();
        elem_t rd;
        int    exp_rd;
        for (int a = 0; a < 32; a++)
        begin
            read_param(cfg_addr_t'(a), rd);
            if (a < DEPTH)
                exp_rd = gamma_model[a];
            else if (a < 2 * DEPTH)
                exp_rd = beta_model[a - DEPTH];
            else
                exp_rd = 0;
            assert (rd == exp_rd)
            else report_mismatch($sformatf("cfg_rdata[%0d]", a), exp_rd, rd);
        end
    endtask

    // Called on a falling edge and returns on the falling edge after the transfer
    task automatic send_vector(input vec_t v);
        logic taken;
        in_data  = v;
        in_valid = 1'b1;
        exp_q.push_back(expected_vector(v));
        taken = 1'b0;
        while (!taken)
        begin
            taken = in_ready;
            @(negedge clk);
        end
        in_valid = 1'b0;
    endtask

    task automatic drain_outputs();
        while (exp_q.size() != 0)
            @(negedge clk);
    endtask

    task automatic end_test(input string name, input int err_start);
        drain_outputs();
        errors = errors + UUT.u_checker.fail_count - checker_fails_seen;
        checker_fails_seen = UUT.u_checker.fail_count;
        tests_run++;
        if (errors != err_start)
            tests_failed++;
        $display("Test %0d, %s: %s with %0d errors", tests_run, name,
                 (errors == err_start) ? "passed" : "failed", errors - err_start);
    endtask

    task automatic check_output();
        vec_t  want;
        elem_t got_e;
        elem_t want_e;
        assert (exp_q.size() != 0)
        else
        begin
            $display("An output vector arrived at %0t with no input vector pending", $time);
            errors++;
        end
        if (exp_q.size() != 0)
        begin
            want = exp_q.pop_front();
            vectors_checked++;
            for (int i = 0; i < DEPTH; i++)
            begin
                got_e  = out_data[i*ELEM_W +: ELEM_W];
                want_e = want[i*ELEM_W +: ELEM_W];
                assert (got_e == want_e)
                else report_mismatch($sformatf("out_data[%0d]", i), want_e, got_e);
                if (got_e == want_e && want_e == 127)
                    sat_hi++;
                if (got_e == want_e && want_e == -128)
                    sat_lo++;
            end
        end
    endtask

    // Output sink drives out_ready and checks each transfer
    initial
    begin
        out_ready = 1'b0;
        sink_seed = SEED;
        forever
        begin
            @(negedge clk);
            if (ready_random)
            begin
                sink_seed = lcg_step(sink_seed);
                out_ready = sink_seed[16];
            end
            else
                out_ready = 1'b1;
            if (rst_n && out_valid && out_ready)
                check_output();
        end
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial
    begin
        int         err_start;
        logic [7:0] c;
        rst_n        = 1'b0;
        in_data      = '0;
        in_valid     = 1'b0;
        cfg_wr_en    = 1'b0;
        cfg_addr     = '0;
        cfg_wdata    = '0;
        ready_random = 1'b0;
        stim_seed    = SEED;
        errors             = 0;
        checker_fails_seen = 0;
        tests_run          = 0;
        tests_failed       = 0;
        vectors_checked    = 0;
        sat_hi             = 0;
        sat_lo             = 0;
        for (int i = 0; i < DEPTH; i++)
        begin
            gamma_model[i] = 16;
            beta_model[i]  = 0;
        end
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        err_start = errors;
        assert (out_valid == 1'b0)
        else report_mismatch("out_valid", 0, out_valid);
        check_param_readback();
        end_test("reset values", err_start);

        // Constant vectors collapse to beta with the default and then distinct values
        err_start = errors;
        for (int n = 0; n < CONST_VECTORS; n++)
        begin
            c = rand_byte();
            send_vector({DEPTH{c}});
        end
        drain_outputs();
        for (int i = 0; i < DEPTH; i++)
            write_param(CFG_BETA_BASE + i, elem_t'(i * 20 - 70));
        for (int n = 0; n < CONST_VECTORS; n++)
        begin
            c = rand_byte();
            send_vector({DEPTH{c}});
        end
        end_test("constant vectors", err_start);
        for (int i = 0; i < DEPTH; i++)
            write_param(CFG_BETA_BASE + i, '0);

        err_start = errors;
        for (int n = 0; n < RANDOM_VECTORS; n++)
            send_vector(random_vector());
        end_test("random vectors, default gamma and beta", err_start);

        // Large gamma on elements 0 and 1 drives both saturation limits
        err_start = errors;
        for (int i = 0; i < DEPTH; i++)
        begin
            write_param(CFG_GAMMA_BASE + i, elem_t'(rand_byte()));
            write_param(CFG_BETA_BASE + i, elem_t'(rand_byte()));
        end
        write_param(CFG_GAMMA_BASE + 0, 8'sd127);
        write_param(CFG_GAMMA_BASE + 1, -8'sd128);
        write_param(CFG_BETA_BASE + 0, '0);
        write_param(CFG_BETA_BASE + 1, '0);
        check_param_readback();
        sat_hi = 0;
        sat_lo = 0;
        for (int n = 0; n < RANDOM_VECTORS; n++)
            send_vector(random_vector());
        drain_outputs();
        assert (sat_hi > 0)
        else
        begin
            $display("No output saturated at 127 in the gamma and beta test");
            errors++;
        end
        assert (sat_lo > 0)
        else
        begin
            $display("No output saturated at -128 in the gamma and beta test");
            errors++;
        end
        end_test("random gamma and beta with saturation", err_start);

        err_start = errors;
        ready_random = 1'b1;
        for (int n = 0; n < RANDOM_VECTORS; n++)
            send_vector(random_vector());
        drain_outputs();
        ready_random = 1'b0;
        end_test("back-to-back with output stalls", err_start);

        $display("Tests run %0d, failed %0d, vectors checked %0d, errors %0d",
                 tests_run, tests_failed, vectors_checked, errors);
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- layer_norm_top.f
source/layer_norm_pkg.sv
source/norm_stats.sv
source/isqrt_unit.sv
source/affine_params.sv
source/norm_scale.sv
source/layer_norm_top.sv
tests/layer_norm_checker.sv
tests/layer_norm_tb.sv
